//--- Bender.yml
package:
  name: axil_subsystem

export_include_dirs:
  - design

sources:
  - design/axil_pkg.sv
  - design/axil_resp_mux.sv
  - design/axil_reg_bank.sv
  - design/axil_addr_decoder.sv
  - design/axil_master.sv
  - design/axil_subsystem.sv
  - target: test
    files:
      - verification/tb_axil_subsystem.sv

//--- design/axil_addr_decoder.sv
`timescale 1ns/1ps
`include "axil_consts.svh"

module axil_addr_decoder (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  axil_pkg::axil_req_t     mst_req,
    output axil_pkg::axil_rsp_t     mst_rsp_ready,
    output axil_pkg::axil_req_t     bank_req [`AXIL_NUM_BANKS],
    input  axil_pkg::axil_rsp_t     bank_rsp [`AXIL_NUM_BANKS],
    output logic [`AXIL_BANK_W-1:0] rd_sel,
    output logic [`AXIL_BANK_W-1:0] wr_sel
);

    logic [`AXIL_BANK_W-1:0] aw_bank;
    logic [`AXIL_BANK_W-1:0] ar_bank;
    logic                    aw_fire;
    logic                    ar_fire;

    // Bank index sits right above the in-bank offset
    assign aw_bank = mst_req.aw_addr[`AXIL_BANK_LSB +: `AXIL_BANK_W];
    assign ar_bank = mst_req.ar_addr[`AXIL_BANK_LSB +: `AXIL_BANK_W];

    always_comb begin
        for (int i = 0; i < `AXIL_NUM_BANKS; i++) begin
            bank_req[i]          = mst_req;
            bank_req[i].aw_valid = mst_req.aw_valid && (aw_bank == `AXIL_BANK_W'(i));
            // W always belongs to the bank of its AW
            bank_req[i].w_valid  = mst_req.w_valid && (aw_bank == `AXIL_BANK_W'(i));
            bank_req[i].ar_valid = mst_req.ar_valid && (ar_bank == `AXIL_BANK_W'(i));
            // Response readies are steered by the response muxes
            bank_req[i].b_ready  = 1'b0;
            bank_req[i].r_ready  = 1'b0;
        end
    end

    always_comb begin
        mst_rsp_ready          = '0;
        mst_rsp_ready.aw_ready = bank_rsp[aw_bank].aw_ready;
        mst_rsp_ready.w_ready  = bank_rsp[aw_bank].w_ready;
        mst_rsp_ready.ar_ready = bank_rsp[ar_bank].ar_ready;
    end

    assign aw_fire = mst_req.aw_valid && mst_rsp_ready.aw_ready;
    assign ar_fire = mst_req.ar_valid && mst_rsp_ready.ar_ready;

    // Remember which bank owes the B and the R
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            wr_sel <= '0;
            rd_sel <= '0;
        end else begin
            if (aw_fire) begin
                wr_sel <= aw_bank;
            end
            if (ar_fire) begin
                rd_sel <= ar_bank;
            end
        end
    end

endmodule

//--- design/axil_consts.svh
`ifndef AXIL_CONSTS_SVH
`define AXIL_CONSTS_SVH

// Bus widths
`define AXIL_AW 12
`define AXIL_DW 32

// Bank array
`define AXIL_NUM_BANKS 4
`define AXIL_BANK_LSB  8
`define AXIL_BANK_W    2

// Word layout inside one bank
`define AXIL_REGS      16
`define AXIL_WORD_LSB  2
`define AXIL_WORD_W    4

// Bits that must be zero for an implemented word
`define AXIL_RANGE_LSB 6
`define AXIL_RANGE_MSB 7

`endif

//--- design/axil_master.sv
`timescale 1ns/1ps
`include "axil_consts.svh"

module axil_master (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 re,
    input  logic                 we,
    input  logic [`AXIL_AW-1:0]  addr,
    input  logic [`AXIL_DW-1:0]  wdata,
    output logic                 busy,
    output logic                 done,
    output logic [`AXIL_DW-1:0]  rdata,
    output axil_pkg::axil_resp_e resp,
    output axil_pkg::axil_req_t  req,
    input  axil_pkg::axil_rsp_t  rsp
);

    typedef enum logic [2:0] {IDLE, WRITE, WRESP, RADDR, RDATA} state_e;

    state_e              state_q;
    state_e              state_d;
    logic                cmd_pending_q;
    logic                cmd_write_q;
    logic [`AXIL_AW-1:0] addr_q;
    logic [`AXIL_DW-1:0] wdata_q;
    logic                accept;
    logic                aw_fire;
    logic                w_fire;
    logic                ar_fire;
    logic                b_fire;
    logic                r_fire;

    // One command at a time, the second pulse of a pair is dropped
    assign accept = (re || we) && (state_q == IDLE) && !cmd_pending_q;
    assign busy   = (state_q != IDLE);

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            cmd_pending_q <= 1'b0;
            cmd_write_q   <= 1'b0;
        end else if (accept) begin
            cmd_pending_q <= 1'b1;
            // Write wins when both strobes arrive together
            cmd_write_q   <= we;
        end else if (cmd_pending_q) begin
            cmd_pending_q <= 1'b0;
        end
    end

    // Latched so the caller holds addr/wdata for one cycle only
    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q  <= addr;
            wdata_q <= wdata;
        end
    end

    always_comb begin
        req          = '0;
        req.aw_valid = (state_q == WRITE);
        req.aw_addr  = addr_q;
        req.w_valid  = (state_q == WRITE);
        req.w_data   = wdata_q;
        req.ar_valid = (state_q == RADDR);
        req.ar_addr  = addr_q;
        req.b_ready  = (state_q == WRESP);
        req.r_ready  = (state_q == RDATA);
    end

    assign aw_fire = req.aw_valid && rsp.aw_ready;
    assign w_fire  = req.w_valid && rsp.w_ready;
    assign ar_fire = req.ar_valid && rsp.ar_ready;
    assign b_fire  = req.b_ready && rsp.b_valid;
    assign r_fire  = req.r_ready && rsp.r_valid;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (cmd_pending_q) begin
                    state_d = cmd_write_q ? WRITE : RADDR;
                end
            end
            // AW and W go out together and complete together
            WRITE: if (aw_fire && w_fire) state_d = WRESP;
            WRESP: if (b_fire) state_d = IDLE;
            RADDR: if (ar_fire) state_d = RDATA;
            RDATA: if (r_fire) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            done <= 1'b0;
        end else begin
            done <= b_fire || r_fire;
        end
    end

    // Result stays put until the next completion
    always_ff @(posedge clk_i) begin
        if (r_fire) begin
            rdata <= rsp.r_data;
            resp  <= rsp.r_resp;
        end else if (b_fire) begin
            resp  <= rsp.b_resp;
        end
    end

endmodule

//--- design/axil_pkg.sv
`include "axil_consts.svh"

package axil_pkg;

    // Only the two codes this design returns
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

    // Everything a manager drives
    typedef struct packed {
        logic                aw_valid;
        logic [`AXIL_AW-1:0] aw_addr;
        logic                w_valid;
        logic [`AXIL_DW-1:0] w_data;
        logic                ar_valid;
        logic [`AXIL_AW-1:0] ar_addr;
        logic                b_ready;
        logic                r_ready;
    } axil_req_t;

    // Everything a subordinate drives
    typedef struct packed {
        logic                aw_ready;
        logic                w_ready;
        logic                ar_ready;
        logic                b_valid;
        axil_resp_e          b_resp;
        logic                r_valid;
        logic [`AXIL_DW-1:0] r_data;
        axil_resp_e          r_resp;
    } axil_rsp_t;

    // R channel payload
    typedef struct packed {
        logic [`AXIL_DW-1:0] data;
        axil_resp_e          resp;
    } axil_r_t;

    // B channel payload
    typedef struct packed {
        axil_resp_e resp;
    } axil_b_t;

endpackage

//--- design/axil_reg_bank.sv
`timescale 1ns/1ps
`include "axil_consts.svh"

module axil_reg_bank (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  axil_pkg::axil_req_t req,
    output axil_pkg::axil_rsp_t rsp
);

    logic [`AXIL_DW-1:0]     regs [`AXIL_REGS];
    logic [`AXIL_WORD_W-1:0] w_idx;
    logic [`AXIL_WORD_W-1:0] r_idx;
    logic                    w_in_range;
    logic                    r_in_range;
    logic                    wr_fire;
    logic                    rd_fire;
    logic                    b_valid_q;
    logic                    r_valid_q;
    axil_pkg::axil_resp_e    b_resp_q;
    axil_pkg::axil_resp_e    r_resp_q;
    logic [`AXIL_DW-1:0]     r_data_q;

    assign w_idx      = req.aw_addr[`AXIL_WORD_LSB +: `AXIL_WORD_W];
    assign r_idx      = req.ar_addr[`AXIL_WORD_LSB +: `AXIL_WORD_W];
    // Upper offset bits select words that do not exist
    assign w_in_range = (req.aw_addr[`AXIL_RANGE_MSB:`AXIL_RANGE_LSB] == '0);
    assign r_in_range = (req.ar_addr[`AXIL_RANGE_MSB:`AXIL_RANGE_LSB] == '0);

    // AW and W only go in as a pair, and only with no B outstanding
    always_comb begin
        rsp          = '0;
        rsp.aw_ready = !b_valid_q && req.w_valid;
        rsp.w_ready  = !b_valid_q && req.aw_valid;
        rsp.ar_ready = !r_valid_q;
        rsp.b_valid  = b_valid_q;
        rsp.b_resp   = b_resp_q;
        rsp.r_valid  = r_valid_q;
        rsp.r_data   = r_data_q;
        rsp.r_resp   = r_resp_q;
    end

    assign wr_fire = req.aw_valid && req.w_valid && rsp.aw_ready;
    assign rd_fire = req.ar_valid && rsp.ar_ready;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            b_valid_q <= 1'b0;
            r_valid_q <= 1'b0;
        end else begin
            if (wr_fire) begin
                b_valid_q <= 1'b1;
            end else if (b_valid_q && req.b_ready) begin
                b_valid_q <= 1'b0;
            end
            if (rd_fire) begin
                r_valid_q <= 1'b1;
            end else if (r_valid_q && req.r_ready) begin
                r_valid_q <= 1'b0;
            end
        end
    end

    // Register file comes out of reset all zero
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            for (int i = 0; i < `AXIL_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_fire && w_in_range) begin
            regs[w_idx] <= req.w_data;
        end
    end

    // Response payloads, held while the valid waits for ready
    always_ff @(posedge clk_i) begin
        if (wr_fire) begin
            b_resp_q <= w_in_range ? axil_pkg::OKAY : axil_pkg::SLVERR;
        end
        if (rd_fire) begin
            r_data_q <= r_in_range ? regs[r_idx] : '0;
            r_resp_q <= r_in_range ? axil_pkg::OKAY : axil_pkg::SLVERR;
        end
    end

endmodule

//--- design/axil_resp_mux.sv
`timescale 1ns/1ps

module axil_resp_mux #(
    parameter type payload_t = logic,
    parameter int  N         = 4
) (
    input  logic [$clog2(N)-1:0] sel,
    input  logic                 in_valid   [N],
    input  payload_t             in_payload [N],
    output logic                 in_ready   [N],
    output logic                 out_valid,
    output payload_t             out_payload,
    input  logic                 out_ready
);

    // Selected channel straight through
    always_comb begin
        out_valid   = in_valid[sel];
        out_payload = in_payload[sel];
    end

    // Ready goes back to the selected input only, others see zero
    always_comb begin
        for (int i = 0; i < N; i++) begin
            in_ready[i] = out_ready && (int'(sel) == i);
        end
    end

endmodule

//--- design/axil_subsystem.sv
`timescale 1ns/1ps
`include "axil_consts.svh"

module axil_subsystem (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 re,
    input  logic                 we,
    input  logic [`AXIL_AW-1:0]  addr,
    input  logic [`AXIL_DW-1:0]  wdata,
    output logic                 busy,
    output logic                 done,
    output logic [`AXIL_DW-1:0]  rdata,
    output axil_pkg::axil_resp_e resp
);

    axil_pkg::axil_req_t     mst_req;
    axil_pkg::axil_rsp_t     mst_rsp;
    axil_pkg::axil_rsp_t     dec_rsp;
    axil_pkg::axil_req_t     dec_req   [`AXIL_NUM_BANKS];
    axil_pkg::axil_req_t     bank_req  [`AXIL_NUM_BANKS];
    axil_pkg::axil_rsp_t     bank_rsp  [`AXIL_NUM_BANKS];
    logic [`AXIL_BANK_W-1:0] rd_sel;
    logic [`AXIL_BANK_W-1:0] wr_sel;
    logic                    r_in_valid [`AXIL_NUM_BANKS];
    axil_pkg::axil_r_t       r_in_data  [`AXIL_NUM_BANKS];
    logic                    r_in_ready [`AXIL_NUM_BANKS];
    logic                    b_in_valid [`AXIL_NUM_BANKS];
    axil_pkg::axil_b_t       b_in_data  [`AXIL_NUM_BANKS];
    logic                    b_in_ready [`AXIL_NUM_BANKS];
    logic                    r_out_valid;
    axil_pkg::axil_r_t       r_out_data;
    logic                    b_out_valid;
    axil_pkg::axil_b_t       b_out_data;

    axil_master i_master (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .re     (re),
        .we     (we),
        .addr   (addr),
        .wdata  (wdata),
        .busy   (busy),
        .done   (done),
        .rdata  (rdata),
        .resp   (resp),
        .req    (mst_req),
        .rsp    (mst_rsp)
    );

    axil_addr_decoder i_decoder (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .mst_req       (mst_req),
        .mst_rsp_ready (dec_rsp),
        .bank_req      (dec_req),
        .bank_rsp      (bank_rsp),
        .rd_sel        (rd_sel),
        .wr_sel        (wr_sel)
    );

    // Request readies from the decoder, responses from the muxes
    always_comb begin
        mst_rsp         = dec_rsp;
        mst_rsp.b_valid = b_out_valid;
        mst_rsp.b_resp  = b_out_data.resp;
        mst_rsp.r_valid = r_out_valid;
        mst_rsp.r_data  = r_out_data.data;
        mst_rsp.r_resp  = r_out_data.resp;
    end

    // Per-bank wiring between decoder, banks and muxes
    always_comb begin
        for (int i = 0; i < `AXIL_NUM_BANKS; i++) begin
            bank_req[i]         = dec_req[i];
            bank_req[i].b_ready = b_in_ready[i];
            bank_req[i].r_ready = r_in_ready[i];
            r_in_valid[i]       = bank_rsp[i].r_valid;
            r_in_data[i]        = '{data: bank_rsp[i].r_data, resp: bank_rsp[i].r_resp};
            b_in_valid[i]       = bank_rsp[i].b_valid;
            b_in_data[i]        = '{resp: bank_rsp[i].b_resp};
        end
    end

    for (genvar i = 0; i < `AXIL_NUM_BANKS; i++) begin : g_bank
        axil_reg_bank i_bank (
            .clk_i  (clk_i),
            .rst_ni (rst_ni),
            .req    (bank_req[i]),
            .rsp    (bank_rsp[i])
        );
    end

    axil_resp_mux #(
        .payload_t (axil_pkg::axil_r_t),
        .N         (`AXIL_NUM_BANKS)
    ) i_r_mux (
        .sel         (rd_sel),
        .in_valid    (r_in_valid),
        .in_payload  (r_in_data),
        .in_ready    (r_in_ready),
        .out_valid   (r_out_valid),
        .out_payload (r_out_data),
        .out_ready   (mst_req.r_ready)
    );

    axil_resp_mux #(
        .payload_t (axil_pkg::axil_b_t),
        .N         (`AXIL_NUM_BANKS)
    ) i_b_mux (
        .sel         (wr_sel),
        .in_valid    (b_in_valid),
        .in_payload  (b_in_data),
        .in_ready    (b_in_ready),
        .out_valid   (b_out_valid),
        .out_payload (b_out_data),
        .out_ready   (mst_req.b_ready)
    );

endmodule

//--- project.f
+incdir+design
design/axil_pkg.sv
design/axil_resp_mux.sv
design/axil_reg_bank.sv
design/axil_addr_decoder.sv
design/axil_master.sv
design/axil_subsystem.sv
verification/tb_axil_subsystem.sv

//--- verification/tb_axil_subsystem.sv
`timescale 1ns/1ps
`include "axil_consts.svh"

module tb_axil_subsystem;

    localparam int DONE_TIMEOUT = 50;
    localparam int WINDOW_MAX   = 60;

    logic                 clk_i;
    logic                 rst_ni;
    logic                 re;
    logic                 we;
    logic [`AXIL_AW-1:0]  addr;
    logic [`AXIL_DW-1:0]  wdata;
    logic                 busy;
    logic                 done;
    logic [`AXIL_DW-1:0]  rdata;
    axil_pkg::axil_resp_e resp;

    // Register model, indexed by {bank, word}
    logic [`AXIL_DW-1:0] model [64];

    string               cur_test;
    int                  errors;
    int                  checks;
    int                  test_start_errors;
    int                  tests_passed;
    int                  tests_failed;
    bit                  timed_out;
    int                  dones;
    int                  quiet;
    int                  cycles;
    bit                  overlapped;
    logic [`AXIL_AW-1:0] a;
    logic [`AXIL_AW-1:0] b;
    logic [`AXIL_DW-1:0] d;

    axil_subsystem uut (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .re     (re),
        .we     (we),
        .addr   (addr),
        .wdata  (wdata),
        .busy   (busy),
        .done   (done),
        .rdata  (rdata),
        .resp   (resp)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic int model_idx(input logic [`AXIL_AW-1:0] ad);
        return {ad[`AXIL_BANK_LSB +: `AXIL_BANK_W], ad[`AXIL_WORD_LSB +: `AXIL_WORD_W]};
    endfunction

    function automatic bit in_range(input logic [`AXIL_AW-1:0] ad);
        return ad[`AXIL_RANGE_MSB:`AXIL_RANGE_LSB] == '0;
    endfunction

    function automatic logic [`AXIL_AW-1:0] rand_in_range();
        logic [`AXIL_AW-1:0] ad;
        ad = `AXIL_AW'($urandom());
        ad[`AXIL_RANGE_MSB:`AXIL_RANGE_LSB] = '0;
        ad[1:0] = 2'b00;
        return ad;
    endfunction

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("[FAIL] %s (%s): expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    // One-cycle command pulse, seen by the DUT on the second edge
    task automatic issue(input logic rd, input logic wr, input logic [`AXIL_AW-1:0] ad,
                         input logic [`AXIL_DW-1:0] dt);
        @(posedge clk_i);
        re    <= rd;
        we    <= wr;
        addr  <= ad;
        wdata <= dt;
        @(posedge clk_i);
        re <= 1'b0;
        we <= 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        @(negedge clk_i);
        while (!done && n < DONE_TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (!done) begin
            $display("Timeout: no done from the DUT within %0d cycles in %s", n, cur_test);
            timed_out = 1'b1;
            errors++;
        end
    endtask

    task automatic finish_write(input logic [`AXIL_AW-1:0] ad, input logic [`AXIL_DW-1:0] dt);
        if (!timed_out) begin
            wait_done();
            check_val("write resp", in_range(ad) ? 32'(axil_pkg::OKAY) : 32'(axil_pkg::SLVERR),
                      32'(resp));
            if (in_range(ad)) begin
                model[model_idx(ad)] = dt;
            end
        end
    endtask

    task automatic write_word(input logic [`AXIL_AW-1:0] ad, input logic [`AXIL_DW-1:0] dt);
        issue(1'b0, 1'b1, ad, dt);
        finish_write(ad, dt);
    endtask

    task automatic read_word(input logic [`AXIL_AW-1:0] ad);
        if (!timed_out) begin
            issue(1'b1, 1'b0, ad, '0);
            wait_done();
            if (!timed_out) begin
                check_val("read data", in_range(ad) ? model[model_idx(ad)] : '0, rdata);
                check_val("read resp",
                          in_range(ad) ? 32'(axil_pkg::OKAY) : 32'(axil_pkg::SLVERR), 32'(resp));
            end
        end
    endtask

    task automatic start_test(input string name);
        cur_test          = name;
        test_start_errors = errors;
    endtask

    task automatic end_test();
        if (errors == test_start_errors) begin
            tests_passed++;
            $display("%-16s ok", cur_test);
        end else begin
            tests_failed++;
            $display("%-16s %0d errors", cur_test, errors - test_start_errors);
        end
    endtask

    initial begin
        void'($urandom(32'hb8825624));
        rst_ni    = 1'b0;
        re        = 1'b0;
        we        = 1'b0;
        addr      = '0;
        wdata     = '0;
        errors    = 0;
        checks    = 0;
        timed_out = 1'b0;
        for (int i = 0; i < 64; i++) begin
            model[i] = '0;
        end
        repeat (8) @(posedge clk_i);
        rst_ni <= 1'b1;

        start_test("reset_values");
        for (int bk = 0; bk < `AXIL_NUM_BANKS; bk++) begin
            read_word(`AXIL_AW'(bk << `AXIL_BANK_LSB));
            read_word(`AXIL_AW'((bk << `AXIL_BANK_LSB) | (5 << `AXIL_WORD_LSB)));
            read_word(`AXIL_AW'((bk << `AXIL_BANK_LSB) | (15 << `AXIL_WORD_LSB)));
        end
        end_test();

        start_test("random_traffic");
        for (int i = 0; i < 300; i++) begin
            a = rand_in_range();
            if ($urandom() % 2) begin
                write_word(a, $urandom());
            end else begin
                read_word(a);
            end
        end
        end_test();

        start_test("bank_isolation");
        a = `AXIL_AW'(9 << `AXIL_WORD_LSB);
        write_word(a, $urandom());
        for (int bk = 0; bk < `AXIL_NUM_BANKS; bk++) begin
            read_word(a | `AXIL_AW'(bk << `AXIL_BANK_LSB));
        end
        end_test();

        start_test("out_of_range");
        for (int i = 0; i < 8; i++) begin
            a = rand_in_range();
            b = a;
            b[`AXIL_RANGE_MSB:`AXIL_RANGE_LSB] = 2'(1 + $urandom() % 3);
            write_word(b, $urandom());
            read_word(b);
            read_word(a);
        end
        end_test();

        start_test("command_rules");
        // Both strobes at once, only the write may happen
        a = rand_in_range();
        d = $urandom();
        issue(1'b1, 1'b1, a, d);
        finish_write(a, d);
        read_word(a);
        // Extra pulse while the FSM is busy must be ignored
        a = rand_in_range();
        b = a ^ `AXIL_AW'(1 << `AXIL_BANK_LSB);
        d = $urandom();
        dones = 0;
        issue(1'b0, 1'b1, a, d);
        cycles = 0;
        @(negedge clk_i);
        while (!busy && cycles < DONE_TIMEOUT) begin
            @(negedge clk_i);
            cycles++;
        end
        @(posedge clk_i);
        re    <= 1'b1;
        we    <= 1'b1;
        addr  <= b;
        wdata <= ~d;
        @(negedge clk_i);
        overlapped = busy;
        if (done) dones++;
        @(posedge clk_i);
        re <= 1'b0;
        we <= 1'b0;
        assert (overlapped) else begin
            $display("Extra command pulse in %s did not fall inside the busy period", cur_test);
            errors++;
        end
        quiet  = 0;
        cycles = 0;
        while (quiet < 4 && cycles < WINDOW_MAX) begin
            @(negedge clk_i);
            cycles++;
            if (done) dones++;
            quiet = (!busy && !done && dones > 0) ? quiet + 1 : 0;
        end
        if (quiet < 4) begin
            $display("Timeout: DUT did not return to idle within %0d cycles", WINDOW_MAX);
            errors++;
        end
        check_val("done pulses", 1, dones);
        check_val("write resp", 32'(axil_pkg::OKAY), 32'(resp));
        model[model_idx(a)] = d;
        read_word(a);
        read_word(b);
        end_test();

        $display("Summary: %0d tests passed, %0d failed, %0d checks, %0d errors",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
